//--- dcore_pkg.sv
package dcore_pkg;

	// datapath widths
	localparam int NTI   = 4;		// interleaved adc lanes
	localparam int NADC  = 8;		// adc magnitude bits
	localparam int NPI   = 9;		// pi code bits
	localparam int NOUT  = 4;		// pi outputs
	localparam int ACC_W = 16;		// phase accumulator bits
	localparam int ERR_W = 20;		// signed phase error bits

	// axi4-lite bus widths
	localparam int AXI_AW = 32;
	localparam int AXI_DW = 32;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// register map, byte addresses
	localparam logic [AXI_AW-1:0] ADDR_CTRL      = 32'h00;	// en, clear, kshift
	localparam logic [AXI_AW-1:0] ADDR_EXT_CODE  = 32'h04;	// open loop code
	localparam logic [AXI_AW-1:0] ADDR_OFS0      = 32'h08;
	localparam logic [AXI_AW-1:0] ADDR_OFS1      = 32'h0C;
	localparam logic [AXI_AW-1:0] ADDR_OFS2      = 32'h10;
	localparam logic [AXI_AW-1:0] ADDR_OFS3      = 32'h14;
	localparam logic [AXI_AW-1:0] ADDR_CODE_STAT = 32'h18;	// read only
	localparam logic [AXI_AW-1:0] ADDR_ERR_STAT  = 32'h1C;	// read only

	typedef struct packed {
		logic            sign;		// 1 means positive
		logic [NADC-1:0] mag;
	} adc_lane_t;

	typedef struct packed {
		adc_lane_t [NTI-1:0] lane;	// lane 0 is the earliest sample
		logic                valid;
	} adc_frame_t;

	typedef struct packed {
		logic                    valid;
		logic signed [ERR_W-1:0] err;	// summed mm timing error
	} pd_out_t;

	typedef struct packed {
		logic                      cdr_en;		// 0 selects ext_code
		logic [2:0]                kshift;		// loop gain as right shift
		logic [NPI-1:0]            ext_code;
		logic [NOUT-1:0][NPI-1:0]  lane_ofs;	// per output code offset
		logic                      acc_clr;		// single cycle pulse
	} cdr_cfg_t;

	typedef struct packed {
		logic              awvalid;
		logic [AXI_AW-1:0] awaddr;
		logic              wvalid;
		logic [AXI_DW-1:0] wdata;
		logic [3:0]        wstrb;		// not decoded, writes are full word
		logic              bready;
		logic              arvalid;
		logic [AXI_AW-1:0] araddr;
		logic              rready;
	} axil_req_t;

	typedef struct packed {
		logic              awready;
		logic              wready;
		logic              bvalid;
		logic [1:0]        bresp;
		logic              arready;
		logic              rvalid;
		logic [AXI_DW-1:0] rdata;
		logic [1:0]        rresp;
	} axil_rsp_t;

endpackage

//--- mm_phase_det.sv
`timescale 1ns/1ps

module mm_phase_det import dcore_pkg::*; (
	input  logic       clk_adc,		// adc retiming clock
	input  logic       rst_n_i,
	input  adc_frame_t adc_i,		// sign magnitude lanes
	output pd_out_t    pd_o			// error one cycle after the frame
);

	// sample sequence, index 0 is last lane of the previous frame
	logic signed [NADC:0]    y [NTI:0];
	logic                    d [NTI:0];	// decision, 1 means +1

	logic signed [NADC:0]    y_hold_q;	// previous lane NTI-1
	logic                    d_hold_q;
	logic signed [ERR_W-1:0] err_sum;
	logic signed [ERR_W-1:0] err_q;
	logic                    valid_q;

	// sign magnitude to two's complement
	function automatic logic signed [NADC:0] sm_to_signed(input adc_lane_t ln);
		logic signed [NADC:0] pos;
		pos = $signed({1'b0, ln.mag});
		return ln.sign ? pos : -pos;
	endfunction

	// multiply by a +1 or -1 decision, widened to the error width
	function automatic logic signed [ERR_W-1:0] apply_dec(
		input logic signed [NADC:0] val,
		input logic                 dec
	);
		logic signed [ERR_W-1:0] ext;
		ext = {{(ERR_W-NADC-1){val[NADC]}}, val};	// sign extend
		return dec ? ext : -ext;
	endfunction

	always_comb begin
		y[0] = y_hold_q;
		d[0] = d_hold_q;
		for (int i = 0; i < NTI; i++) begin
			y[i+1] = sm_to_signed(adc_i.lane[i]);
			d[i+1] = adc_i.lane[i].sign;			// slicer is the sign bit
		end
	end

	// y[k]*d[k-1] - y[k-1]*d[k] over adjacent pairs
	always_comb begin
		err_sum = '0;
		for (int k = 1; k <= NTI; k++) begin
			err_sum = err_sum + apply_dec(y[k], d[k-1]) - apply_dec(y[k-1], d[k]);
		end
	end

	always_ff @(posedge clk_adc or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q  <= 1'b0;
			y_hold_q <= '0;			// zero sample
			d_hold_q <= 1'b1;		// with +1 decision
		end else begin
			valid_q <= adc_i.valid;
			if (adc_i.valid) begin
				y_hold_q <= y[NTI];	// carry last lane into next frame
				d_hold_q <= d[NTI];
			end
		end
	end

	// error payload, only meaningful with valid_q
	always_ff @(posedge clk_adc) begin
		if (adc_i.valid) begin
			err_q <= err_sum;
		end
	end

	always_comb begin
		pd_o.valid = valid_q;
		pd_o.err   = err_q;
	end

endmodule

//--- dcore_csr.sv
`timescale 1ns/1ps

module dcore_csr import dcore_pkg::*; (
	input  logic           clk_adc,
	input  logic           rst_n_i,
	input  axil_req_t      axil_req_i,	// master to slave
	output axil_rsp_t      axil_rsp_o,	// slave to master
	input  pd_out_t        pd_i,		// for err status
	input  logic [NPI-1:0] cdr_code_i,	// current loop code
	output cdr_cfg_t       cfg_o
);

	cdr_cfg_t          cfg_q;			// writable fields
	logic [AXI_DW-1:0] err_stat_q;		// last valid error, sign extended

	logic              wr_rdy_q;		// drives awready and wready
	logic              bvalid_q;
	logic [1:0]        bresp_q;
	logic              rd_rdy_q;		// drives arready
	logic              rvalid_q;
	logic [AXI_DW-1:0] rdata_q;
	logic [1:0]        rresp_q;

	logic              wr_hs;
	logic              rd_hs;
	logic              wr_hit;			// write address is mapped
	logic              rd_hit;			// read address is mapped
	logic [AXI_DW-1:0] rd_data;

	// valids stay up until accepted, so ready alone marks the beat
	assign wr_hs = wr_rdy_q & axil_req_i.awvalid & axil_req_i.wvalid;
	assign rd_hs = rd_rdy_q & axil_req_i.arvalid;

	always_comb begin
		case (axil_req_i.awaddr)
			ADDR_CTRL,
			ADDR_EXT_CODE,
			ADDR_OFS0,
			ADDR_OFS1,
			ADDR_OFS2,
			ADDR_OFS3,
			ADDR_CODE_STAT,
			ADDR_ERR_STAT: wr_hit = 1'b1;	// status writes are dropped
			default:       wr_hit = 1'b0;
		endcase
	end

	// read mux
	always_comb begin
		rd_hit  = 1'b1;
		rd_data = '0;						// unmapped reads return 0
		case (axil_req_i.araddr)
			ADDR_CTRL:      rd_data = {25'd0, cfg_q.kshift, 3'b000, cfg_q.cdr_en};
			ADDR_EXT_CODE:  rd_data = AXI_DW'(cfg_q.ext_code);
			ADDR_OFS0:      rd_data = AXI_DW'(cfg_q.lane_ofs[0]);
			ADDR_OFS1:      rd_data = AXI_DW'(cfg_q.lane_ofs[1]);
			ADDR_OFS2:      rd_data = AXI_DW'(cfg_q.lane_ofs[2]);
			ADDR_OFS3:      rd_data = AXI_DW'(cfg_q.lane_ofs[3]);
			ADDR_CODE_STAT: rd_data = AXI_DW'(cdr_code_i);
			ADDR_ERR_STAT:  rd_data = err_stat_q;
			default:        rd_hit  = 1'b0;
		endcase
	end

	// write address and data channels taken together, then response
	always_ff @(posedge clk_adc or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_rdy_q <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			// single cycle ready, blocked while a response is pending
			wr_rdy_q <= !wr_rdy_q && !bvalid_q && axil_req_i.awvalid && axil_req_i.wvalid;
			if (wr_hs) begin
				bvalid_q <= 1'b1;
			end else if (axil_req_i.bready) begin
				bvalid_q <= 1'b0;			// response taken
			end
		end
	end

	// read address channel and read data hold
	always_ff @(posedge clk_adc or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_rdy_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			rd_rdy_q <= !rd_rdy_q && !rvalid_q && axil_req_i.arvalid;
			if (rd_hs) begin
				rvalid_q <= 1'b1;
			end else if (axil_req_i.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	// response payload, stable while the matching valid waits
	always_ff @(posedge clk_adc) begin
		if (wr_hs) begin
			bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
		end
		if (rd_hs) begin
			rdata_q <= rd_data;
			rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// config registers
	always_ff @(posedge clk_adc or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cfg_q <= '0;
		end else begin
			cfg_q.acc_clr <= 1'b0;			// pulse lasts one cycle
			if (wr_hs) begin
				case (axil_req_i.awaddr)
					ADDR_CTRL: begin
						cfg_q.cdr_en  <= axil_req_i.wdata[0];
						cfg_q.acc_clr <= axil_req_i.wdata[1];	// self clearing
						cfg_q.kshift  <= axil_req_i.wdata[6:4];
					end
					ADDR_EXT_CODE: cfg_q.ext_code    <= axil_req_i.wdata[NPI-1:0];
					ADDR_OFS0:     cfg_q.lane_ofs[0] <= axil_req_i.wdata[NPI-1:0];
					ADDR_OFS1:     cfg_q.lane_ofs[1] <= axil_req_i.wdata[NPI-1:0];
					ADDR_OFS2:     cfg_q.lane_ofs[2] <= axil_req_i.wdata[NPI-1:0];
					ADDR_OFS3:     cfg_q.lane_ofs[3] <= axil_req_i.wdata[NPI-1:0];
					default: ;						// status or unmapped
				endcase
			end
		end
	end

	// phase error snapshot
	always_ff @(posedge clk_adc or negedge rst_n_i) begin
		if (!rst_n_i) begin
			err_stat_q <= '0;
		end else if (pd_i.valid) begin
			err_stat_q <= {{(AXI_DW-ERR_W){pd_i.err[ERR_W-1]}}, pd_i.err};
		end
	end

	always_comb begin
		axil_rsp_o.awready = wr_rdy_q;
		axil_rsp_o.wready  = wr_rdy_q;
		axil_rsp_o.bvalid  = bvalid_q;
		axil_rsp_o.bresp   = bresp_q;
		axil_rsp_o.arready = rd_rdy_q;
		axil_rsp_o.rvalid  = rvalid_q;
		axil_rsp_o.rdata   = rdata_q;
		axil_rsp_o.rresp   = rresp_q;
	end

	assign cfg_o = cfg_q;

endmodule

//--- pi_ctl_gen.sv
`timescale 1ns/1ps

module pi_ctl_gen import dcore_pkg::*; (
	input  logic           clk_adc,
	input  logic           rst_n_i,
	input  pd_out_t        pd_i,			// phase error from detector
	input  cdr_cfg_t       cfg_i,			// register settings
	output logic [NPI-1:0] pi_ctl_o [NOUT-1:0],	// code per pi output
	output logic [NPI-1:0] cdr_code_o		// loop code for status
);

	logic [ACC_W-1:0]        acc_q;			// phase accumulator
	logic [ACC_W-1:0]        acc_nxt;
	logic signed [ERR_W-1:0] err_shr;		// error scaled by loop gain
	logic [NPI-1:0]          base_code;

	// gain as arithmetic right shift
	assign err_shr = $signed(pd_i.err) >>> cfg_i.kshift;

	always_comb begin
		if (cfg_i.acc_clr) begin
			acc_nxt = '0;						// clear wins
		end else if (pd_i.valid && cfg_i.cdr_en) begin
			acc_nxt = acc_q + err_shr[ACC_W-1:0];	// wraps mod 2^ACC_W
		end else begin
			acc_nxt = acc_q;
		end
	end

	// closed loop follows the updated accumulator on the same edge
	assign base_code = cfg_i.cdr_en ? acc_nxt[ACC_W-1 -: NPI] : cfg_i.ext_code;

	always_ff @(posedge clk_adc or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc_q <= '0;
		end else begin
			acc_q <= acc_nxt;
		end
	end

	always_ff @(posedge clk_adc or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int k = 0; k < NOUT; k++) begin
				pi_ctl_o[k] <= '0;
			end
		end else begin
			for (int k = 0; k < NOUT; k++) begin
				pi_ctl_o[k] <= base_code + cfg_i.lane_ofs[k];	// mod 2^NPI
			end
		end
	end

	assign cdr_code_o = acc_q[ACC_W-1 -: NPI];	// top bits of accumulator

endmodule

//--- dcore_cdr_top.sv
`timescale 1ns/1ps

module dcore_cdr_top import dcore_pkg::*; (
	input  logic           clk_adc,				// adc clock, also bus clock
	input  logic           rst_n_i,
	input  adc_frame_t     adc_i,				// frame from analog core
	input  axil_req_t      axil_req_i,			// register port
	output axil_rsp_t      axil_rsp_o,
	output logic [NPI-1:0] pi_ctl_o [NOUT-1:0]	// pi control codes
);

	pd_out_t        pd;			// timing error with valid
	cdr_cfg_t       cfg;		// register settings to code gen
	logic [NPI-1:0] cdr_code;	// loop code back to status

	// mueller muller detector on main lanes
	mm_phase_det u_mm_phase_det (
		.clk_adc(clk_adc),
		.rst_n_i(rst_n_i),
		.adc_i  (adc_i),
		.pd_o   (pd)
	);

	// config and status registers
	dcore_csr u_dcore_csr (
		.clk_adc   (clk_adc),
		.rst_n_i   (rst_n_i),
		.axil_req_i(axil_req_i),
		.axil_rsp_o(axil_rsp_o),
		.pd_i      (pd),
		.cdr_code_i(cdr_code),
		.cfg_o     (cfg)
	);

	// loop filter and output codes
	pi_ctl_gen u_pi_ctl_gen (
		.clk_adc   (clk_adc),
		.rst_n_i   (rst_n_i),
		.pd_i      (pd),
		.cfg_i     (cfg),
		.pi_ctl_o  (pi_ctl_o),
		.cdr_code_o(cdr_code)
	);

endmodule

//--- tb_dcore_model.svh
`ifndef TB_DCORE_MODEL_SVH
`define TB_DCORE_MODEL_SVH

typedef struct packed {
	logic                     cdr_en;
	logic [2:0]               kshift;
	logic [NPI-1:0]           ext_code;
	logic [NOUT-1:0][NPI-1:0] ofs;
	logic                     clr;		// pulse acc clear after setup
	logic [7:0]               nfrm;		// frames streamed for this row
	logic                     rnd;		// 1 random frames, 0 fixed pattern
} row_t;

localparam int NROWS = 12;

row_t        stim [NROWS];
logic [31:0] lfsr_q = 32'he367ac61;
int          m_hold_y;					// model copy of held lane 3
int          m_hold_d;
int          m_acc;
int          m_last_err;

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] take_bits(input int n);
	logic [31:0] val;
	logic        fb;
	val = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		val = {val[30:0], lfsr_q[0]};
	end
	return val;
endfunction

task automatic set_row(input int r, input logic en, input logic [2:0] ks,
	input logic [NPI-1:0] ext, input logic [NOUT-1:0][NPI-1:0] ofs,
	input logic clr, input logic [7:0] n, input logic rnd);
	stim[r] = '{en, ks, ext, ofs, clr, n, rnd};
endtask

task automatic init_table();
	set_row(0,  1'b0, 3'd0, 9'h000, {9'h000, 9'h000, 9'h000, 9'h000}, 1'b0, 8'd4,  1'b0);
	set_row(1,  1'b0, 3'd0, 9'h0a5, {9'h004, 9'h003, 9'h002, 9'h001}, 1'b0, 8'd6,  1'b0);
	set_row(2,  1'b0, 3'd0, 9'h1f0, {9'h1ff, 9'h00f, 9'h010, 9'h020}, 1'b0, 8'd6,  1'b1);
	set_row(3,  1'b1, 3'd0, 9'h000, {9'h000, 9'h000, 9'h000, 9'h000}, 1'b1, 8'd20, 1'b1);
	for (int k = 1; k < 8; k++) begin		// each remaining loop gain
		set_row(3 + k, 1'b1, 3'(k), 9'h055, {9'h180, 9'h0c0, 9'h040, 9'h001},
			1'b0, 8'd16, 1'b1);
	end
	set_row(11, 1'b1, 3'd2, 9'h000, {9'h1f8, 9'h100, 9'h008, 9'h000}, 1'b1, 8'd8, 1'b0);
endtask

// mueller muller error of one frame, updates held sample
task automatic pd_model(input adc_frame_t f, output int err);
	int ys [NTI+1];
	int ds [NTI+1];
	ys[0] = m_hold_y;
	ds[0] = m_hold_d;
	for (int i = 0; i < NTI; i++) begin
		ys[i+1] = f.lane[i].sign ? int'(f.lane[i].mag) : -int'(f.lane[i].mag);
		ds[i+1] = f.lane[i].sign ? 1 : -1;
	end
	err = 0;
	for (int k = 1; k <= NTI; k++) begin
		err = err + ys[k] * ds[k-1] - ys[k-1] * ds[k];
	end
	m_hold_y = ys[NTI];
	m_hold_d = ds[NTI];
endtask

`endif

//--- tb_dcore_cdr.sv
`timescale 1ns/1ps

module tb_dcore_cdr import dcore_pkg::*; ();

	logic           clk_adc = 1'b0;
	logic           rst_n_i;
	adc_frame_t     adc;
	axil_req_t      axil_req;
	axil_rsp_t      axil_rsp;
	logic [NPI-1:0] pi_ctl [NOUT-1:0];

	int                     errors = 0;
	int                     cycles = 0;
	int                     limit  = 1000000;	// replaced once the table is known
	logic [NOUT*NPI-1:0]    exp_q [$];			// expected codes, two frame delay

	`include "tb_dcore_model.svh"

	dcore_cdr_top u_dcore_cdr_top (
		.clk_adc   (clk_adc),
		.rst_n_i   (rst_n_i),
		.adc_i     (adc),
		.axil_req_i(axil_req),
		.axil_rsp_o(axil_rsp),
		.pi_ctl_o  (pi_ctl)
	);

	always #5 clk_adc = ~clk_adc;

	always @(posedge clk_adc) begin
		cycles++;
		if (cycles >= limit) begin
			$display("run stopped, cycle limit %0d reached before the tests ended", limit);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (exp == got) else begin
			$display("Fail %s exp %h got %h at %0t", name, exp, got, $time);
			errors++;
		end
	endtask

	task automatic tick();
		@(posedge clk_adc);
		#1;			// drive and sample just after the edge
	endtask

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr  = addr;
		axil_req.wvalid  = 1'b1;
		axil_req.wdata   = data;
		axil_req.bready  = 1'b1;
		do tick(); while (!(axil_rsp.awready && axil_rsp.wready));
		tick();			// beat taken on this edge
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		while (!axil_rsp.bvalid) tick();
		resp = axil_rsp.bresp;
		tick();
		axil_req.bready = 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] addr, input int hold,
		output logic [31:0] data, output logic [1:0] resp);
		axil_req.arvalid = 1'b1;
		axil_req.araddr  = addr;
		axil_req.rready  = 1'b0;
		do tick(); while (!axil_rsp.arready);
		tick();
		axil_req.arvalid = 1'b0;
		while (!axil_rsp.rvalid) tick();
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		for (int i = 0; i < hold; i++) begin	// master stalls the data channel
			tick();
			check_val("rvalid held", 32'd1, 32'(axil_rsp.rvalid));
			check_val("rdata held", data, axil_rsp.rdata);
		end
		axil_req.rready = 1'b1;
		tick();
		axil_req.rready = 1'b0;
	endtask

	task automatic write_ok(input logic [31:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check_val("bresp", 32'(RESP_OKAY), 32'(resp));
	endtask

	task automatic read_expect(input string name, input logic [31:0] addr,
		input logic [31:0] exp);
		logic [31:0] data;
		logic [1:0]  resp;
		axi_read(addr, 0, data, resp);
		check_val("rresp", 32'(RESP_OKAY), 32'(resp));
		check_val(name, exp, data);
	endtask

	function automatic logic [NOUT*NPI-1:0] predict_codes(input row_t r);
		logic [NPI-1:0]           base;
		logic [NOUT-1:0][NPI-1:0] out;
		base = r.cdr_en ? NPI'(m_acc >> (ACC_W - NPI)) : r.ext_code;
		for (int k = 0; k < NOUT; k++) begin
			out[k] = base + r.ofs[k];		// wraps at 2^NPI
		end
		return out;
	endfunction

	task automatic compare_codes();
		logic [NOUT-1:0][NPI-1:0] exp;
		exp = exp_q.pop_front();
		for (int k = 0; k < NOUT; k++) begin
			check_val($sformatf("pi_ctl_o[%0d]", k), 32'(exp[k]), 32'(pi_ctl[k]));
		end
	endtask

	task automatic stream_frames(input row_t r);
		adc_frame_t f;
		int         err;
		for (int n = 0; n < int'(r.nfrm); n++) begin
			tick();
			if (exp_q.size() >= 2) compare_codes();
			f.valid = 1'b1;
			for (int i = 0; i < NTI; i++) begin
				if (r.rnd) begin
					f.lane[i].sign = 1'(take_bits(1));
					f.lane[i].mag  = NADC'(take_bits(NADC));
				end else begin
					f.lane[i].sign = ((n + i) % 3) != 0;
					f.lane[i].mag  = NADC'(16 * i + 7 * n + 3);
				end
			end
			pd_model(f, err);
			m_last_err = err;
			if (r.cdr_en) m_acc = (m_acc + (err >>> r.kshift)) & 32'hffff;
			exp_q.push_back(predict_codes(r));
			adc = f;
		end
		for (int i = 0; i < 2; i++) begin		// drain the two frame latency
			tick();
			adc.valid = 1'b0;
			if (exp_q.size() > 0) compare_codes();
		end
	endtask

	task automatic program_row(input row_t r);
		write_ok(ADDR_EXT_CODE, 32'(r.ext_code));
		write_ok(ADDR_OFS0, 32'(r.ofs[0]));
		write_ok(ADDR_OFS1, 32'(r.ofs[1]));
		write_ok(ADDR_OFS2, 32'(r.ofs[2]));
		write_ok(ADDR_OFS3, 32'(r.ofs[3]));
		write_ok(ADDR_CTRL, {25'd0, r.kshift, 2'b00, r.clr, r.cdr_en});
		if (r.clr) m_acc = 0;
	endtask

	initial begin
		logic [31:0] data;
		logic [1:0]  resp;
		int          total;
		rst_n_i  = 1'b0;
		adc      = '0;
		axil_req = '0;
		m_hold_y = 0;
		m_hold_d = 1;			// held decision starts at +1
		m_acc    = 0;
		init_table();
		total = 0;
		for (int r = 0; r < NROWS; r++) total += int'(stim[r].nfrm) + 120;
		limit = 2 * (total + 300);
		repeat (5) @(posedge clk_adc);
		#1 rst_n_i = 1'b1;
		tick();
		for (int k = 0; k < NOUT; k++) check_val("pi_ctl_o reset", 32'd0, 32'(pi_ctl[k]));
		read_expect("CTRL", ADDR_CTRL, 32'd0);
		read_expect("EXT_CODE", ADDR_EXT_CODE, 32'd0);
		read_expect("OFS0", ADDR_OFS0, 32'd0);
		read_expect("OFS1", ADDR_OFS1, 32'd0);
		read_expect("OFS2", ADDR_OFS2, 32'd0);
		read_expect("OFS3", ADDR_OFS3, 32'd0);
		for (int r = 0; r < NROWS; r++) begin
			program_row(stim[r]);
			if (stim[r].clr) read_expect("CODE_STAT cleared", ADDR_CODE_STAT, 32'd0);
			// clear bit never reads back
			read_expect("CTRL", ADDR_CTRL, {25'd0, stim[r].kshift, 3'b000, stim[r].cdr_en});
			stream_frames(stim[r]);
			read_expect("ERR_STAT", ADDR_ERR_STAT, 32'(m_last_err));
			read_expect("CODE_STAT", ADDR_CODE_STAT, 32'((m_acc >> (ACC_W - NPI)) & 'h1ff));
		end
		// unmapped accesses and a stalled read
		axi_read(32'h40, 0, data, resp);
		check_val("rresp unmapped", 32'(RESP_SLVERR), 32'(resp));
		check_val("rdata unmapped", 32'd0, data);
		axi_write(32'h44, 32'hffff_ffff, resp);
		check_val("bresp unmapped", 32'(RESP_SLVERR), 32'(resp));
		read_expect("EXT_CODE kept", ADDR_EXT_CODE, 32'(stim[NROWS-1].ext_code));
		read_expect("OFS1 kept", ADDR_OFS1, 32'(stim[NROWS-1].ofs[1]));
		axi_read(ADDR_OFS2, 3, data, resp);		// nonzero value held on the bus
		check_val("rresp stalled", 32'(RESP_OKAY), 32'(resp));
		check_val("OFS2 stalled", 32'(stim[NROWS-1].ofs[2]), data);
		$display("checks done, errors = %0d", errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- build.f
dcore_pkg.sv
mm_phase_det.sv
dcore_csr.sv
pi_ctl_gen.sv
dcore_cdr_top.sv
tb_dcore_cdr.sv
+incdir+.

//--- Makefile
# Verilator build and run of the CDR digital core testbench

TOP = tb_dcore_cdr

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	rm -f sim.log
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
